/* design/ls_pkg.sv */
// Load/store package with operation fields, access types and address-space rules
`default_nettype none

package ls_pkg;

  // Width of one load/store operation word
  localparam int LS_OP_W = 15;

  // Single-bit fields of the operation
  localparam int OP_STORE_BIT = 14;
  localparam int OP_UPD_BIT   = 13;
  localparam int OP_WORD_BIT  = 12;
  localparam int OP_HALF_BIT  = 11;

  // Offset field starts at bit 6 and ends at bit 11 for words, bit 10 otherwise
  localparam int OFF_LSB     = 6;
  localparam int OFF_W_WORD  = 6;
  localparam int OFF_W_SMALL = 5;

  // Pointer register select sits in bits 5:3, data register select in bits 2:0
  localparam int PTR_LSB  = 3;
  localparam int DATA_LSB = 0;

  // Datapath and register-file select widths
  localparam int XLEN      = 32;
  localparam int REG_SEL_W = 3;

  // Addresses with this bit set belong to the external bus
  localparam int EXT_SPACE_BIT = 31;

  // Cycles from an accepted load to its register write
  localparam int LOAD_LATENCY = 3;

  // Access size, decoded with the word bit taking precedence over the half bit
  typedef enum logic [1:0] {
    LS_BYTE = 2'd0,
    LS_HALF = 2'd1,
    LS_WORD = 2'd2
  } ls_size_e;

  // Access direction straight from the store bit
  typedef enum logic {
    LS_LOAD  = 1'b0,
    LS_STORE = 1'b1
  } ls_dir_e;

endpackage

`default_nettype wire

/* design/dbus_if.sv */
// Data bus and register-file port bundles shared by the load/store blocks
`default_nettype none

// No-wait data bus between the issue stage, the data RAM and the load aligner
interface dbus_if import ls_pkg::*; ();

  // Word-aligned address of the access
  logic [XLEN-1:0] addr;
  // One access per cycle with cs high
  logic            cs;
  logic            wr;
  // Byte enables, lane n covers address offset n
  logic [3:0]      mask;
  logic [XLEN-1:0] wdata;
  // Read data, valid in the cycle after a read access
  logic [XLEN-1:0] rdata;

  modport issue (output addr, output cs, output wr, output mask, output wdata);
  modport mem   (input addr, input cs, input wr, input mask, input wdata, output rdata);
  modport align (input rdata);

endinterface

// Register-file read selects, read data and the two load/store write ports
interface regfile_if import ls_pkg::*; ();

  // Combinational read ports for the pointer and store data
  logic [REG_SEL_W-1:0] ptr_sel;
  logic [REG_SEL_W-1:0] store_sel;
  logic [XLEN-1:0]      ptr;
  logic [XLEN-1:0]      store;

  // Pointer write-back from the issue stage
  logic                 upd_vld;
  logic [REG_SEL_W-1:0] upd_sel;
  logic [XLEN-1:0]      upd;

  // Aligned load data from the load pipeline
  logic                 load_vld;
  logic [REG_SEL_W-1:0] load_sel;
  logic [XLEN-1:0]      load;

  modport issue (output ptr_sel, output store_sel, input ptr, input store,
                 output upd_vld, output upd_sel, output upd);
  modport align (output load_vld, output load_sel, output load);
  modport rf    (input ptr_sel, input store_sel, output ptr, output store,
                 input upd_vld, input upd_sel, input upd,
                 input load_vld, input load_sel, input load);

endinterface

`default_nettype wire

/* design/ls_issue.sv */
// Load/store issue stage that forms the address and sends one bus request per operation
`default_nettype none

module ls_issue import ls_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 op_vld,
  input  logic [LS_OP_W-1:0]   op,
  regfile_if.issue             rf,
  dbus_if.issue                bus,
  output logic                 ext_cs,
  output logic [REG_SEL_W-1:0] ext_tag,
  output logic [XLEN-1:0]      ext_addr,
  output logic                 ext_wr,
  output logic [3:0]           ext_mask,
  output logic [XLEN-1:0]      ext_wdata,
  output logic                 ld_start,
  output ls_size_e             ld_size,
  output logic [1:0]           ld_lane,
  output logic [REG_SEL_W-1:0] ld_sel
);

  ls_size_e             size;
  ls_dir_e              dir;
  logic                 upd;
  logic                 off_neg;
  logic [5:0]           off_field;
  logic [XLEN-1:0]      off_ext;
  logic [XLEN-1:0]      off_scaled;
  logic [XLEN-1:0]      next_ptr;
  logic [XLEN-1:0]      addr;
  logic                 ext_space;
  logic [3:0]           mask;
  logic [XLEN-1:0]      wdata;
  logic [REG_SEL_W-1:0] data_sel;

  // Register reads happen in the issue cycle
  assign rf.ptr_sel   = op[PTR_LSB +: REG_SEL_W];
  assign rf.store_sel = op[DATA_LSB +: REG_SEL_W];
  assign data_sel     = op[DATA_LSB +: REG_SEL_W];

  assign dir = ls_dir_e'(op[OP_STORE_BIT]);
  assign upd = op[OP_UPD_BIT];

  always_comb
  begin
    if (op[OP_WORD_BIT])
      size = LS_WORD;
    else if (op[OP_HALF_BIT])
      size = LS_HALF;
    else
      size = LS_BYTE;
  end

  // Offset is only signed when the pointer is written back
  always_comb
  begin
    if (size == LS_WORD)
    begin
      off_neg   = upd & op[OFF_LSB + OFF_W_WORD - 1];
      off_field = op[OFF_LSB +: OFF_W_WORD];
    end
    else
    begin
      off_neg   = upd & op[OFF_LSB + OFF_W_SMALL - 1];
      off_field = {off_neg, op[OFF_LSB +: OFF_W_SMALL]};
    end
    off_ext = {{(XLEN - 6){off_neg}}, off_field};
  end

  // Scale the offset by the access size
  always_comb
  begin
    case (size)
      LS_WORD: off_scaled = off_ext << 2;
      LS_HALF: off_scaled = off_ext << 1;
      default: off_scaled = off_ext;
    endcase
  end

  assign next_ptr = rf.ptr + off_scaled;

  // Post-increment uses the old pointer, pre-decrement and plain offsets use the sum
  assign addr      = (upd && !off_neg) ? rf.ptr : next_ptr;
  assign ext_space = addr[EXT_SPACE_BIT];

  // Byte enables follow the address, halves sit on the half selected by bit 1
  always_comb
  begin
    case (size)
      LS_WORD: mask = 4'b1111;
      LS_HALF: mask = addr[1] ? 4'b1100 : 4'b0011;
      default: mask = 4'b0001 << addr[1:0];
    endcase
  end

  // Store data is replicated so every lane carries the value
  always_comb
  begin
    case (size)
      LS_WORD: wdata = rf.store;
      LS_HALF: wdata = {2{rf.store[15:0]}};
      default: wdata = {4{rf.store[7:0]}};
    endcase
  end

  // Strobes last one cycle and clear on reset
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      bus.cs     <= 1'b0;
      ext_cs     <= 1'b0;
      rf.upd_vld <= 1'b0;
      ld_start   <= 1'b0;
    end
    else
    begin
      bus.cs     <= op_vld & ~ext_space;
      ext_cs     <= op_vld & ext_space;
      rf.upd_vld <= op_vld & upd;
      // Only loads to the data RAM return data to the register file
      ld_start   <= op_vld & ~ext_space & (dir == LS_LOAD);
    end
  end

  // Request payload, pointer update and load descriptor
  always_ff @(posedge CLK)
  begin
    if (op_vld)
    begin
      bus.addr   <= {addr[XLEN-1:2], 2'b00};
      bus.wr     <= (dir == LS_STORE);
      bus.mask   <= mask;
      bus.wdata  <= wdata;
      ext_tag    <= data_sel;
      ext_addr   <= {addr[XLEN-1:2], 2'b00};
      ext_wr     <= (dir == LS_STORE);
      ext_mask   <= mask;
      ext_wdata  <= wdata;
      rf.upd_sel <= op[PTR_LSB +: REG_SEL_W];
      rf.upd     <= next_ptr;
      ld_size    <= size;
      ld_lane    <= addr[1:0];
      ld_sel     <= data_sel;
    end
  end

endmodule

`default_nettype wire

/* design/ls_load_align.sv */
// Load pipeline that follows RAM reads and aligns the returned data into a register write
`default_nettype none

module ls_load_align import ls_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 ld_start,
  input  ls_size_e             ld_size,
  input  logic [1:0]           ld_lane,
  input  logic [REG_SEL_W-1:0] ld_sel,
  dbus_if.align                bus,
  regfile_if.align             rf
);

  // Stage 2 waits for the RAM read, stage 3 holds the captured word
  logic                 s2_vld;
  ls_size_e             s2_size;
  logic [1:0]           s2_lane;
  logic [REG_SEL_W-1:0] s2_sel;
  logic                 s3_vld;
  ls_size_e             s3_size;
  logic [1:0]           s3_lane;
  logic [REG_SEL_W-1:0] s3_sel;
  logic [XLEN-1:0]      rd_word;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      s2_vld <= 1'b0;
      s3_vld <= 1'b0;
    end
    else
    begin
      s2_vld <= ld_start;
      s3_vld <= s2_vld;
    end
  end

  always_ff @(posedge CLK)
  begin
    s2_size <= ld_size;
    s2_lane <= ld_lane;
    s2_sel  <= ld_sel;
    s3_size <= s2_size;
    s3_lane <= s2_lane;
    s3_sel  <= s2_sel;
    // RAM data is valid while stage 2 holds its load
    if (s2_vld)
      rd_word <= bus.rdata;
  end

  assign rf.load_vld = s3_vld;
  assign rf.load_sel = s3_sel;

  // Pick the addressed lane and zero-extend, a word passes through as is
  always_comb
  begin
    case (s3_size)
      LS_WORD: rf.load = rd_word;
      LS_HALF: rf.load = s3_lane[1] ? {16'd0, rd_word[31:16]} : {16'd0, rd_word[15:0]};
      default:
      begin
        case (s3_lane)
          2'd0:    rf.load = {24'd0, rd_word[7:0]};
          2'd1:    rf.load = {24'd0, rd_word[15:8]};
          2'd2:    rf.load = {24'd0, rd_word[23:16]};
          default: rf.load = {24'd0, rd_word[31:24]};
        endcase
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/ls_regfile.sv */
// Eight-entry register file with pointer, store and host read ports and prioritized writes
`default_nettype none

module ls_regfile import ls_pkg::*; (
  input  logic                 CLK,
  input  logic                 RST,
  regfile_if.rf                rf,
  input  logic                 host_wr,
  input  logic [REG_SEL_W-1:0] host_sel,
  input  logic [XLEN-1:0]      host_wdata,
  input  logic [REG_SEL_W-1:0] host_rsel,
  output logic [XLEN-1:0]      host_rdata
);

  localparam int NREGS = 2 ** REG_SEL_W;

  logic [XLEN-1:0] regs [NREGS];

  // Each register picks its own writer, so distinct targets all update
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < NREGS; i++)
        regs[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < NREGS; i++)
      begin
        // Load data beats the pointer update, which beats the host
        if (rf.load_vld && rf.load_sel == REG_SEL_W'(i))
          regs[i] <= rf.load;
        else if (rf.upd_vld && rf.upd_sel == REG_SEL_W'(i))
          regs[i] <= rf.upd;
        else if (host_wr && host_sel == REG_SEL_W'(i))
          regs[i] <= host_wdata;
      end
    end
  end

  // Reads see the register contents before this cycle's writes
  assign rf.ptr     = regs[rf.ptr_sel];
  assign rf.store   = regs[rf.store_sel];
  assign host_rdata = regs[host_rsel];

endmodule

`default_nettype wire

/* design/ls_dram.sv */
// Byte-masked on-chip data RAM with one cycle of read latency
`default_nettype none

module ls_dram import ls_pkg::*; #(
  parameter int DRAM_AW = 8
) (
  input  logic CLK,
  dbus_if.mem  bus
);

  localparam int DEPTH = 2 ** DRAM_AW;
  localparam int LANES = XLEN / 8;

  logic [XLEN-1:0]    mem [DEPTH];
  logic [DRAM_AW-1:0] widx;

  // Word index from the byte address, upper address bits alias
  assign widx = bus.addr[DRAM_AW+1:2];

  always_ff @(posedge CLK)
  begin
    if (bus.cs)
    begin
      if (bus.wr)
      begin
        // Only enabled lanes change
        for (int b = 0; b < LANES; b++)
        begin
          if (bus.mask[b])
            mem[widx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
      else
      begin
        bus.rdata <= mem[widx];
      end
    end
  end

endmodule

`default_nettype wire

/* design/ls_top.sv */
// Load/store subsystem top with issue, load alignment, register file and data RAM
`default_nettype none

module ls_top import ls_pkg::*; #(
  parameter int DRAM_AW = 8
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 op_vld,
  input  logic [LS_OP_W-1:0]   op,
  input  logic                 host_wr,
  input  logic [REG_SEL_W-1:0] host_sel,
  input  logic [XLEN-1:0]      host_wdata,
  input  logic [REG_SEL_W-1:0] host_rsel,
  output logic [XLEN-1:0]      host_rdata,
  output logic                 ext_cs,
  output logic [REG_SEL_W-1:0] ext_tag,
  output logic [XLEN-1:0]      ext_addr,
  output logic                 ext_wr,
  output logic [3:0]           ext_mask,
  output logic [XLEN-1:0]      ext_wdata
);

  // Load descriptor handed from issue to the load pipeline
  logic                 ld_start;
  ls_size_e             ld_size;
  logic [1:0]           ld_lane;
  logic [REG_SEL_W-1:0] ld_sel;

  dbus_if    bus ();
  regfile_if rf ();

  ls_issue u_issue (
    .CLK       (CLK),
    .RST       (RST),
    .op_vld    (op_vld),
    .op        (op),
    .rf        (rf.issue),
    .bus       (bus.issue),
    .ext_cs    (ext_cs),
    .ext_tag   (ext_tag),
    .ext_addr  (ext_addr),
    .ext_wr    (ext_wr),
    .ext_mask  (ext_mask),
    .ext_wdata (ext_wdata),
    .ld_start  (ld_start),
    .ld_size   (ld_size),
    .ld_lane   (ld_lane),
    .ld_sel    (ld_sel)
  );

  ls_load_align u_load_align (
    .CLK      (CLK),
    .RST      (RST),
    .ld_start (ld_start),
    .ld_size  (ld_size),
    .ld_lane  (ld_lane),
    .ld_sel   (ld_sel),
    .bus      (bus.align),
    .rf       (rf.align)
  );

  ls_regfile u_regfile (
    .CLK        (CLK),
    .RST        (RST),
    .rf         (rf.rf),
    .host_wr    (host_wr),
    .host_sel   (host_sel),
    .host_wdata (host_wdata),
    .host_rsel  (host_rsel),
    .host_rdata (host_rdata)
  );

  ls_dram #(
    .DRAM_AW (DRAM_AW)
  ) u_dram (
    .CLK (CLK),
    .bus (bus.mem)
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
// Testbench clock and reset source for the load/store subsystem
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 16
) (
  output logic CLK,
  output logic RST
);

  // Free-running clock that starts low
  initial
  begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset drops on a rising edge once the cycle count is reached
  initial
  begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    RST <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/ls_tb.sv */
// Testbench for the load/store subsystem with RAM and register reference models
`default_nettype none

module ls_tb import ls_pkg::*; ();

  localparam int RST_CYCLES = 16;
  localparam int DRAM_AW    = 8;
  localparam int N_SUB      = 24;
  localparam int N_EXT      = 4;
  // Every test op with its host traffic fits in eight cycles
  localparam int N_OPS      = 2 + (4 + N_SUB + 4 * 7) + 6 * 2 + 2 * N_EXT + 7;
  localparam int TIMEOUT    = RST_CYCLES + 8 * N_OPS + 100;
  localparam logic [31:0] WIN = 32'h100;

  logic                 CLK;
  logic                 RST;
  logic                 op_vld;
  logic [LS_OP_W-1:0]   op;
  logic                 host_wr;
  logic [REG_SEL_W-1:0] host_sel;
  logic [XLEN-1:0]      host_wdata;
  logic [REG_SEL_W-1:0] host_rsel;
  logic [XLEN-1:0]      host_rdata;
  logic                 ext_cs;
  logic [REG_SEL_W-1:0] ext_tag;
  logic [XLEN-1:0]      ext_addr;
  logic                 ext_wr;
  logic [3:0]           ext_mask;
  logic [XLEN-1:0]      ext_wdata;

  // Reference models of the RAM bytes and the registers
  logic [7:0]  ram_model [4 * 2 ** DRAM_AW];
  logic [31:0] reg_model [8];
  logic [31:0] last_addr;
  logic [31:0] seed = 32'he4ce_79e1;
  logic        ext_exp = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          mark = 0;
  int          cycles = 0;

  tb_clk_gen #(.PERIOD(20), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.CLK(CLK), .RST(RST));

  ls_top #(.DRAM_AW(DRAM_AW)) dut (
    .CLK(CLK), .RST(RST), .op_vld(op_vld), .op(op),
    .host_wr(host_wr), .host_sel(host_sel), .host_wdata(host_wdata),
    .host_rsel(host_rsel), .host_rdata(host_rdata),
    .ext_cs(ext_cs), .ext_tag(ext_tag), .ext_addr(ext_addr),
    .ext_wr(ext_wr), .ext_mask(ext_mask), .ext_wdata(ext_wdata)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int size_shift(ls_size_e sz);
    return (sz == LS_WORD) ? 2 : (sz == LS_HALF) ? 1 : 0;
  endfunction

  function automatic logic [14:0] make_op(logic st, logic upd, ls_size_e sz, logic [5:0] off,
                                          logic [2:0] ptr, logic [2:0] data);
    logic [14:0] o;
    o = '0;
    o[OP_STORE_BIT] = st;
    o[OP_UPD_BIT]   = upd;
    o[OP_WORD_BIT]  = (sz == LS_WORD);
    o[OP_HALF_BIT]  = (sz == LS_HALF);
    if (sz == LS_WORD)
      o[11:6] = off;
    else
      o[10:6] = off[4:0];
    o[5:3] = ptr;
    o[2:0] = data;
    return o;
  endfunction

  // Offset field is signed only with pointer update, then scaled by the size
  function automatic logic [31:0] scaled_off(ls_size_e sz, logic upd, logic [5:0] off);
    logic [31:0] v;
    if (sz == LS_WORD)
      v = {{26{upd & off[5]}}, off};
    else
      v = {{27{upd & off[4]}}, off[4:0]};
    return v << size_shift(sz);
  endfunction

  function automatic logic [3:0] lane_mask(ls_size_e sz, logic [1:0] lane);
    if (sz == LS_WORD)
      return 4'b1111;
    if (sz == LS_HALF)
      return lane[1] ? 4'b1100 : 4'b0011;
    return 4'b0001 << lane;
  endfunction

  function automatic logic [31:0] replicate(ls_size_e sz, logic [31:0] d);
    if (sz == LS_WORD)
      return d;
    if (sz == LS_HALF)
      return {2{d[15:0]}};
    return {4{d[7:0]}};
  endfunction

  // Unsigned offset field that stays inside the 16-byte window
  function automatic logic [5:0] window_off(ls_size_e sz, logic [31:0] r);
    if (sz == LS_WORD)
      return {4'd0, r[1:0]};
    if (sz == LS_HALF)
      return {3'd0, r[2:0]};
    return {2'd0, r[3:0]};
  endfunction

  task automatic model_store(logic [31:0] a, ls_size_e sz, logic [31:0] d);
    logic [3:0]  m;
    logic [31:0] w;
    m = lane_mask(sz, a[1:0]);
    w = replicate(sz, d);
    for (int b = 0; b < 4; b++)
      if (m[b])
        ram_model[{a[DRAM_AW+1:2], 2'(b)}] = w[8*b +: 8];
  endtask

  // Selected lane of the addressed word, zero-extended
  function automatic logic [31:0] model_load(logic [31:0] a, ls_size_e sz);
    logic [31:0] w;
    for (int b = 0; b < 4; b++)
      w[8*b +: 8] = ram_model[{a[DRAM_AW+1:2], 2'(b)}];
    case (sz)
      LS_WORD: return w;
      LS_HALF: return {16'd0, w[16*a[1] +: 16]};
      default: return {24'd0, w[8*a[1:0] +: 8]};
    endcase
  endfunction

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    assert (got === exp) else
    begin
      errors++;
      $display("error at time %0t: %s expected %h actual %h", $time, name, exp, got);
    end
  endtask

  task automatic host_write(logic [2:0] sel, logic [31:0] d);
    host_wr    <= 1'b1;
    host_sel   <= sel;
    host_wdata <= d;
    @(posedge CLK);
    host_wr    <= 1'b0;
    reg_model[sel] = d;
  endtask

  // Host read port is combinational, so sample it in the middle of the cycle
  task automatic check_reg(logic [2:0] sel);
    host_rsel <= sel;
    @(negedge CLK);
    check_val($sformatf("host_rdata(r%0d)", sel), host_rdata, reg_model[sel]);
    @(posedge CLK);
  endtask

  task automatic issue_op(logic [14:0] o);
    op_vld <= 1'b1;
    op     <= o;
    @(posedge CLK);
    op_vld <= 1'b0;
  endtask

  task automatic run_op(logic st, logic upd, ls_size_e sz, logic [5:0] off,
                        logic [2:0] ptr, logic [2:0] data);
    logic [31:0] base;
    logic [31:0] so;
    base = reg_model[ptr];
    so   = scaled_off(sz, upd, off);
    // Post-increment uses the old pointer, every other form the sum
    last_addr = (upd && !so[31]) ? base : base + so;
    issue_op(make_op(st, upd, sz, off, ptr, data));
    if (upd)
      reg_model[ptr] = base + so;
    if (st && !last_addr[EXT_SPACE_BIT])
      model_store(last_addr, sz, reg_model[data]);
    if (!st && !last_addr[EXT_SPACE_BIT])
    begin
      repeat (LOAD_LATENCY) @(posedge CLK);
      reg_model[data] = model_load(last_addr, sz);
      check_reg(data);
    end
  endtask

  task automatic finish_test(string name);
    $display("%-10s finished with %0d errors", name, errors - mark);
    mark = errors;
  endtask

  // ext_cs must stay low outside the one cycle a test expects it
  always @(negedge CLK)
  begin
    if (cycles > 0 && !ext_exp)
      check_val("ext_cs", ext_cs, 32'd0);
  end

  always @(posedge CLK)
  begin
    cycles++;
    if (cycles > TIMEOUT)
    begin
      $display("timeout after %0d cycles with tests still running", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] r;
    logic [31:0] a;
    logic [5:0]  off;
    ls_size_e    sz;
    logic        st;
    op_vld     = 1'b0;
    op         = '0;
    host_wr    = 1'b0;
    host_sel   = '0;
    host_wdata = '0;
    host_rsel  = '0;
    foreach (ram_model[i])
      ram_model[i] = 'x;
    foreach (reg_model[i])
      reg_model[i] = '0;
    @(negedge RST);
    @(posedge CLK);

    for (int i = 0; i < 8; i++)
      check_reg(3'(i));
    finish_test("reset");

    host_write(1, 32'h40);
    host_write(2, next_rand());
    run_op(1'b1, 1'b0, LS_WORD, 6'd3, 1, 2);
    run_op(1'b0, 1'b0, LS_WORD, 6'd3, 1, 3);
    finish_test("word");

    // Fill the window with words, then overwrite bytes and halves on every lane
    host_write(1, WIN);
    for (int w = 0; w < 4; w++)
    begin
      host_write(2, next_rand());
      run_op(1'b1, 1'b0, LS_WORD, 6'(w), 1, 2);
    end
    for (int i = 0; i < N_SUB; i++)
    begin
      r  = next_rand();
      a  = 32'((i / 2) % 4);
      sz = (i % 2 == 1) ? LS_HALF : LS_BYTE;
      off = (sz == LS_HALF) ? {3'd0, r[1:0], a[1]} : {2'd0, r[1:0], a[1:0]};
      host_write(2, next_rand());
      run_op(1'b1, 1'b0, sz, off, 1, 2);
    end
    for (int w = 0; w < 4; w++)
    begin
      run_op(1'b0, 1'b0, LS_WORD, 6'(w), 1, 3);
      for (int b = 0; b < 4; b++)
        run_op(1'b0, 1'b0, LS_BYTE, 6'(4 * w + b), 1, 3);
      for (int h = 0; h < 2; h++)
        run_op(1'b0, 1'b0, LS_HALF, 6'(2 * w + h), 1, 3);
    end
    finish_test("subword");

    // Negative offsets give a pre-decrement, the rest a post-increment
    for (int s = 0; s < 3; s++)
      for (int d = 0; d < 2; d++)
      begin
        sz  = ls_size_e'(s);
        r   = next_rand();
        off = (sz == LS_WORD) ? {d[0], r[4:0]} : {1'b0, d[0], r[3:0]};
        host_write(4, WIN + 32'h80);
        host_write(5, next_rand());
        run_op(1'b1, 1'b1, sz, off, 4, 5);
        @(posedge CLK);
        check_reg(4);
        // A plain load at the expected address shows where the store landed
        host_write(6, last_addr);
        run_op(1'b0, 1'b0, sz, 6'd0, 6, 7);
      end
    finish_test("pointer");

    for (int i = 0; i < N_EXT; i++)
    begin
      r  = next_rand();
      // Sizes rotate and loads alternate with stores so both kinds reach the bus
      sz = ls_size_e'(i % 3);
      st = i[0];
      host_write(1, 32'h8000_0000 | WIN);
      host_write(2, next_rand());
      run_op(st, 1'b0, sz, window_off(sz, r >> 4), 1, 2);
      ext_exp = 1'b1;
      @(negedge CLK);
      check_val("ext_cs", ext_cs, 32'd1);
      check_val("ext_tag", ext_tag, 32'd2);
      check_val("ext_addr", ext_addr, {last_addr[31:2], 2'b00});
      check_val("ext_wr", ext_wr, st);
      check_val("ext_mask", ext_mask, lane_mask(sz, last_addr[1:0]));
      if (st)
        check_val("ext_wdata", ext_wdata, replicate(sz, reg_model[2]));
      @(posedge CLK);
      ext_exp = 1'b0;
      repeat (LOAD_LATENCY) @(posedge CLK);
      check_reg(2);
      // The aliased RAM word still holds the model contents
      host_write(1, last_addr & 32'h7fff_fffc);
      run_op(1'b0, 1'b0, LS_WORD, 6'd0, 1, 3);
    end
    finish_test("external");

    // Seven loads back to back, each to its own register
    host_write(0, WIN);
    for (int i = 1; i < 8; i++)
    begin
      r   = next_rand();
      sz  = ls_size_e'(r[1:0] % 3);
      off = window_off(sz, r >> 2);
      reg_model[i] = model_load(WIN + scaled_off(sz, 1'b0, off), sz);
      op_vld <= 1'b1;
      op     <= make_op(1'b0, 1'b0, sz, off, 0, 3'(i));
      @(posedge CLK);
    end
    op_vld <= 1'b0;
    repeat (LOAD_LATENCY) @(posedge CLK);
    for (int i = 0; i < 8; i++)
      check_reg(3'(i));
    finish_test("pipeline");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
design/ls_pkg.sv
design/dbus_if.sv
design/ls_issue.sv
design/ls_load_align.sv
design/ls_regfile.sv
design/ls_dram.sv
design/ls_top.sv
verif/tb_clk_gen.sv
verif/ls_tb.sv

/* Bender.yml */
package:
  name: ls_subsystem

sources:
  - design/ls_pkg.sv
  - design/dbus_if.sv
  - design/ls_issue.sv
  - design/ls_load_align.sv
  - design/ls_regfile.sv
  - design/ls_dram.sv
  - design/ls_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/ls_tb.sv
